/* sources.f */
verilog/cp0_pkg.sv
verilog/cp0_access_port.sv
verilog/except_prioritizer.sv
verilog/cp0_regs.sv
verilog/cp0_top.sv
testbench/cp0_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cp0_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/cp0_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_tb;

	localparam int          TIMEOUT = 100;	// cycles per wait
	localparam logic [31:0] VECTOR  = 32'h8000_0180;

	// flags from highest to lowest priority, with the code each one raises
	localparam int RANK_FLAG [9] = '{cp0_pkg::FLAG_ADEL, cp0_pkg::FLAG_TLBL,
		cp0_pkg::FLAG_RI, cp0_pkg::FLAG_CPU, cp0_pkg::FLAG_SYS, cp0_pkg::FLAG_ADES,
		cp0_pkg::FLAG_TLBS, cp0_pkg::FLAG_MOD, cp0_pkg::FLAG_WATCH};
	localparam logic [4:0] RANK_CODE [9] = '{cp0_pkg::EXC_ADEL, cp0_pkg::EXC_TLBL,
		cp0_pkg::EXC_RI, cp0_pkg::EXC_CPU, cp0_pkg::EXC_SYS, cp0_pkg::EXC_ADES,
		cp0_pkg::EXC_TLBS, cp0_pkg::EXC_MOD, cp0_pkg::EXC_WATCH};

	logic        clk;
	logic        arst_n;
	logic        req;
	logic        we;
	logic [4:0]  addr;
	logic [31:0] wdata;
	logic        ack;
	logic [31:0] rdata;
	logic        commit_valid;
	logic [8:0]  exc_flags;
	logic        eret;
	logic [31:0] inst_addr;
	logic        in_delay_slot;
	logic [5:0]  int_lines;
	logic        flush;
	logic [31:0] new_pc;
	logic        timer_int;
	logic [31:0] rand_state;

	cp0_top #(
		.CPU_NUM (10'd5)
	) dut (
		.clk             (clk),
		.arst_n_i        (arst_n),
		.req_i           (req),
		.we_i            (we),
		.addr_i          (addr),
		.wdata_i         (wdata),
		.ack_o           (ack),
		.rdata_o         (rdata),
		.commit_valid_i  (commit_valid),
		.exc_flags_i     (exc_flags),
		.eret_i          (eret),
		.inst_addr_i     (inst_addr),
		.in_delay_slot_i (in_delay_slot),
		.int_i           (int_lines),
		.flush_o         (flush),
		.new_pc_o        (new_pc),
		.timer_int_o     (timer_int)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// cause word as capture leaves it with the ip bits clear
	function automatic logic [31:0] cause_word(input logic bd, input logic [4:0] code);
		return {bd, 24'd0, code, 2'b00};
	endfunction

	function automatic logic [4:0] expected_code(input logic [8:0] flags);
		logic [4:0] code;
		logic       found;
		int         i;
		code  = 5'd0;
		found = 1'b0;
		for (i = 0; i < 9; i++) begin
			if (!found && flags[RANK_FLAG[i]]) begin
				code  = RANK_CODE[i];
				found = 1'b1;
			end
		end
		return code;
	endfunction

	task automatic stop_run();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("ERROR at %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level) begin
			if (n == TIMEOUT) begin
				$display("ack never went to %0d within %0d cycles", level, TIMEOUT);
				stop_run();
			end
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	// one four-phase handshake returning the value latched with ack
	task automatic access(input logic write, input logic [4:0] a, input logic [31:0] d,
			output logic [31:0] q);
		@(posedge clk);
		#1;
		req   = 1'b1;
		we    = write;
		addr  = a;
		wdata = d;
		wait_ack(1'b1);
		q   = rdata;
		req = 1'b0;
		we  = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic cp0_write(input logic [4:0] a, input logic [31:0] d);
		logic [31:0] old_value;
		access(1'b1, a, d, old_value);
	endtask

	task automatic cp0_read(input logic [4:0] a, output logic [31:0] q);
		access(1'b0, a, 32'd0, q);
	endtask

	// one pipeline cycle with the redirect sampled mid-cycle
	task automatic commit(input logic [8:0] flags, input logic is_eret, input logic [31:0] pc,
			input logic ds, output logic fl, output logic [31:0] npc);
		@(posedge clk);
		#1;
		commit_valid  = 1'b1;
		exc_flags     = flags;
		eret          = is_eret;
		inst_addr     = pc;
		in_delay_slot = ds;
		#1;
		fl  = flush;
		npc = new_pc;
		@(posedge clk);
		#1;
		commit_valid  = 1'b0;
		exc_flags     = '0;
		eret          = 1'b0;
		in_delay_slot = 1'b0;
	endtask

	task automatic reset_values();
		logic [4:0]  zero_regs [7] = '{cp0_pkg::REG_INDEX, cp0_pkg::REG_ENTRYLO0,
			cp0_pkg::REG_ENTRYLO1, cp0_pkg::REG_ENTRYHI, cp0_pkg::REG_COMPARE,
			cp0_pkg::REG_CAUSE, cp0_pkg::REG_EPC};
		logic [31:0] v;
		logic [31:0] c1;
		logic [31:0] c2;
		int          i;
		check_eq({29'd0, ack, flush, timer_int}, 32'd0, "ack/flush/timer after reset");
		cp0_read(cp0_pkg::REG_STATUS, v);
		check_eq(v, 32'h1000_0000, "status reset");
		cp0_read(cp0_pkg::REG_EBASE, v);
		check_eq(v, 32'h8000_0005, "ebase reset");
		for (i = 0; i < 7; i++) begin
			cp0_read(zero_regs[i], v);
			check_eq(v, 32'd0, $sformatf("reg %0d reset", zero_regs[i]));
		end
		cp0_read(cp0_pkg::REG_COUNT, c1);
		cp0_read(cp0_pkg::REG_COUNT, c2);
		assert (c2 > c1) else begin
			$display("ERROR at %0t: count went 0x%08h then 0x%08h", $time, c1, c2);
			stop_run();
		end
	endtask

	task automatic check_mask(input logic [4:0] a, input logic [31:0] mask, input string what);
		logic [31:0] w;
		logic [31:0] v;
		int          k;
		for (k = 0; k < 3; k++) begin
			w = (k == 2) ? 32'hFFFF_FFFF : next_rand();
			cp0_write(a, w);
			cp0_read(a, v);
			check_eq(v, w & mask, what);
		end
	endtask

	task automatic write_masks();
		check_mask(cp0_pkg::REG_INDEX, cp0_pkg::MASK_INDEX, "index mask");
		check_mask(cp0_pkg::REG_ENTRYLO0, cp0_pkg::MASK_ENTRYLO, "entrylo0 mask");
		check_mask(cp0_pkg::REG_ENTRYLO1, cp0_pkg::MASK_ENTRYLO, "entrylo1 mask");
		check_mask(cp0_pkg::REG_BADVADDR, 32'hFFFF_FFFF, "badvaddr");
		check_mask(cp0_pkg::REG_ENTRYHI, cp0_pkg::MASK_ENTRYHI, "entryhi mask");
		check_mask(cp0_pkg::REG_COMPARE, 32'hFFFF_FFFF, "compare");
		check_mask(cp0_pkg::REG_STATUS, 32'hFFFF_FFFF, "status");
		check_mask(cp0_pkg::REG_CAUSE, cp0_pkg::MASK_CAUSE_W, "cause mask");
		check_mask(cp0_pkg::REG_EPC, 32'hFFFF_FFFF, "epc");
		check_mask(cp0_pkg::REG_EBASE, cp0_pkg::MASK_EBASE, "ebase mask");
		// back to a quiet state for the exception tests
		cp0_write(cp0_pkg::REG_COMPARE, 32'd0);
		cp0_write(cp0_pkg::REG_STATUS, 32'h1000_0000);
		cp0_write(cp0_pkg::REG_CAUSE, 32'd0);
		cp0_write(cp0_pkg::REG_EBASE, 32'h8000_0005);
	endtask

	task automatic capture_and_eret();
		logic [31:0] a;
		logic [31:0] c;
		logic [31:0] v;
		logic [31:0] pc;
		logic        fl;
		a = 32'h0040_1000;
		c = 32'h0040_2000;
		commit(9'd1 << cp0_pkg::FLAG_SYS, 1'b0, a, 1'b0, fl, pc);
		check_eq({31'd0, fl}, 32'd1, "flush on syscall");
		check_eq(pc, VECTOR, "vector on syscall");
		cp0_read(cp0_pkg::REG_EPC, v);
		check_eq(v, a, "epc after syscall");
		cp0_read(cp0_pkg::REG_CAUSE, v);
		check_eq(v, cause_word(1'b0, cp0_pkg::EXC_SYS), "cause after syscall");
		cp0_read(cp0_pkg::REG_STATUS, v);
		check_eq(v, 32'h1000_0002, "exl after syscall");
		// nested exception keeps epc and bd
		commit(9'd1 << cp0_pkg::FLAG_RI, 1'b0, a + 32'h20, 1'b1, fl, pc);
		check_eq({31'd0, fl}, 32'd1, "flush on nested");
		cp0_read(cp0_pkg::REG_EPC, v);
		check_eq(v, a, "epc after nested");
		cp0_read(cp0_pkg::REG_CAUSE, v);
		check_eq(v, cause_word(1'b0, cp0_pkg::EXC_RI), "cause after nested");
		commit(9'd0, 1'b1, a + 32'h40, 1'b0, fl, pc);
		check_eq({31'd0, fl}, 32'd1, "flush on eret");
		check_eq(pc, a, "eret target");
		cp0_read(cp0_pkg::REG_STATUS, v);
		check_eq(v, 32'h1000_0000, "exl after eret");
		commit(9'd1 << cp0_pkg::FLAG_ADES, 1'b0, c, 1'b1, fl, pc);
		cp0_read(cp0_pkg::REG_EPC, v);
		check_eq(v, c - 32'd4, "epc in delay slot");
		cp0_read(cp0_pkg::REG_CAUSE, v);
		check_eq(v, cause_word(1'b1, cp0_pkg::EXC_ADES), "cause in delay slot");
		commit(9'd0, 1'b1, c, 1'b0, fl, pc);
		check_eq(pc, c - 32'd4, "eret to branch");
	endtask

	task automatic priority_order();
		logic [31:0] r;
		logic [31:0] v;
		logic [31:0] pc;
		logic [8:0]  flags;
		logic        fl;
		int          k;
		for (k = 0; k < 16; k++) begin
			r     = next_rand();
			flags = r[24:16];	// upper lcg bits vary more than the low ones
			if (flags == 9'd0) begin
				flags = 9'd1 << cp0_pkg::FLAG_WATCH;
			end
			commit(flags, 1'b0, 32'h0040_0100 + r[15:0], 1'b0, fl, pc);
			check_eq({31'd0, fl}, 32'd1, "flush on combined flags");
			check_eq(pc, VECTOR, "vector on combined flags");
			cp0_read(cp0_pkg::REG_CAUSE, v);
			check_eq({27'd0, v[6:2]}, {27'd0, expected_code(flags)},
				$sformatf("exccode for flags 0x%03h", flags));
		end
		commit(9'd0, 1'b1, 32'd0, 1'b0, fl, pc);	// leave exl clear
	endtask

	task automatic interrupt_gating();
		logic [31:0] d;
		logic [31:0] v;
		logic [31:0] pc;
		logic        fl;
		d = 32'h0040_3000;
		@(posedge clk);
		#1;
		int_lines = 6'b000001;	// ip2
		cp0_write(cp0_pkg::REG_STATUS, 32'h1000_0401);
		commit(9'd0, 1'b0, d, 1'b0, fl, pc);
		check_eq({31'd0, fl}, 32'd1, "flush on interrupt");
		check_eq(pc, VECTOR, "vector on interrupt");
		cp0_read(cp0_pkg::REG_CAUSE, v);
		check_eq(v, cause_word(1'b0, cp0_pkg::EXC_INT) | 32'h400, "cause on interrupt");
		commit(9'd0, 1'b0, d, 1'b0, fl, pc);
		check_eq({31'd0, fl}, 32'd0, "no flush with exl set");
		commit(9'd0, 1'b1, d, 1'b0, fl, pc);
		check_eq(pc, d, "eret from interrupt");
		cp0_write(cp0_pkg::REG_STATUS, 32'h1000_0001);	// im2 off
		commit(9'd0, 1'b0, d, 1'b0, fl, pc);
		check_eq({31'd0, fl}, 32'd0, "no flush with mask clear");
		@(posedge clk);
		#1;
		int_lines = 6'b000000;
		cp0_write(cp0_pkg::REG_STATUS, 32'h1000_0000);
	endtask

	task automatic timer_compare();
		logic [31:0] c;
		logic [31:0] v;
		int          n;
		cp0_read(cp0_pkg::REG_COUNT, c);
		cp0_write(cp0_pkg::REG_COMPARE, c + 32'd40);
		n = 0;
		while (timer_int !== 1'b1) begin
			if (n == TIMEOUT) begin
				$display("timer interrupt did not rise within %0d cycles", TIMEOUT);
				stop_run();
			end
			@(posedge clk);
			#1;
			n++;
		end
		cp0_read(cp0_pkg::REG_CAUSE, v);
		check_eq({31'd0, v[15]}, 32'd1, "cause ip7 with timer");
		cp0_write(cp0_pkg::REG_COMPARE, c + 32'd40);
		check_eq({31'd0, timer_int}, 32'd0, "timer after compare write");
		cp0_read(cp0_pkg::REG_CAUSE, v);
		check_eq({31'd0, v[15]}, 32'd0, "cause ip7 after compare write");
	endtask

	initial begin
		arst_n        = 1'b0;
		req           = 1'b0;
		we            = 1'b0;
		addr          = 5'd0;
		wdata         = 32'd0;
		commit_valid  = 1'b0;
		exc_flags     = '0;
		eret          = 1'b0;
		inst_addr     = 32'd0;
		in_delay_slot = 1'b0;
		int_lines     = 6'd0;
		rand_state    = 32'h5413;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_values();
		write_masks();
		capture_and_eret();
		priority_order();
		interrupt_gating();
		timer_compare();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cp0_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_top #(
	parameter logic [9:0] CPU_NUM = 10'd0
) (
	input  wire                        clk,
	input  wire                        arst_n_i,

	// host access
	input  wire                        req_i,
	input  wire                        we_i,
	input  wire  [4:0]                 addr_i,
	input  wire  [cp0_pkg::WORD_W-1:0] wdata_i,
	output logic                       ack_o,
	output logic [cp0_pkg::WORD_W-1:0] rdata_o,

	// pipeline commit
	input  wire                        commit_valid_i,
	input  wire  [cp0_pkg::FLAG_N-1:0] exc_flags_i,
	input  wire                        eret_i,
	input  wire  [cp0_pkg::WORD_W-1:0] inst_addr_i,
	input  wire                        in_delay_slot_i,

	input  wire  [5:0]                 int_i,

	output logic                       flush_o,
	output logic [cp0_pkg::WORD_W-1:0] new_pc_o,
	output logic                       timer_int_o
);

	logic                       acc_we;
	logic [4:0]                 acc_addr;
	logic [cp0_pkg::WORD_W-1:0] acc_wdata;
	logic [cp0_pkg::WORD_W-1:0] acc_rdata;

	logic                       exc_take;
	logic [4:0]                 exc_code;
	logic                       exc_eret;
	logic [cp0_pkg::WORD_W-1:0] exc_addr;
	logic                       exc_bd;

	logic [cp0_pkg::WORD_W-1:0] status;
	logic [cp0_pkg::WORD_W-1:0] cause;
	logic [cp0_pkg::WORD_W-1:0] epc;
	logic [cp0_pkg::WORD_W-1:0] ebase;

	cp0_access_port u_port (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_i       (req_i),
		.we_i        (we_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.ack_o       (ack_o),
		.rdata_o     (rdata_o),
		.reg_rdata_i (acc_rdata),
		.reg_we_o    (acc_we),
		.reg_addr_o  (acc_addr),
		.reg_wdata_o (acc_wdata)
	);

	except_prioritizer u_prio (
		.commit_valid_i  (commit_valid_i),
		.exc_flags_i     (exc_flags_i),
		.eret_i          (eret_i),
		.inst_addr_i     (inst_addr_i),
		.in_delay_slot_i (in_delay_slot_i),
		.status_i        (status),
		.cause_i         (cause),
		.epc_i           (epc),
		.ebase_i         (ebase),
		.take_o          (exc_take),
		.code_o          (exc_code),
		.eret_o          (exc_eret),
		.epc_new_o       (exc_addr),
		.bd_o            (exc_bd),
		.flush_o         (flush_o),
		.new_pc_o        (new_pc_o)
	);

	// one address serves both read and write of the single access
	cp0_regs #(
		.CPU_NUM (CPU_NUM)
	) u_regs (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.we_i        (acc_we),
		.waddr_i     (acc_addr),
		.wdata_i     (acc_wdata),
		.raddr_i     (acc_addr),
		.rdata_o     (acc_rdata),
		.int_i       (int_i),
		.exc_take_i  (exc_take),
		.exc_code_i  (exc_code),
		.exc_eret_i  (exc_eret),
		.exc_epc_i   (exc_addr),
		.exc_bd_i    (exc_bd),
		.status_o    (status),
		.cause_o     (cause),
		.epc_o       (epc),
		.ebase_o     (ebase),
		.timer_int_o (timer_int_o)
	);

endmodule

`default_nettype wire

/* verilog/cp0_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_regs #(
	parameter logic [9:0] CPU_NUM = 10'd0
) (
	input  wire                        clk,
	input  wire                        arst_n_i,

	// access port strobes
	input  wire                        we_i,
	input  wire  [4:0]                 waddr_i,
	input  wire  [cp0_pkg::WORD_W-1:0] wdata_i,
	input  wire  [4:0]                 raddr_i,
	output logic [cp0_pkg::WORD_W-1:0] rdata_o,

	// hardware interrupt lines
	input  wire  [5:0]                 int_i,

	// exception capture
	input  wire                        exc_take_i,
	input  wire  [4:0]                 exc_code_i,
	input  wire                        exc_eret_i,
	input  wire  [cp0_pkg::WORD_W-1:0] exc_epc_i,
	input  wire                        exc_bd_i,

	output logic [cp0_pkg::WORD_W-1:0] status_o,
	output logic [cp0_pkg::WORD_W-1:0] cause_o,
	output logic [cp0_pkg::WORD_W-1:0] epc_o,
	output logic [cp0_pkg::WORD_W-1:0] ebase_o,
	output logic                       timer_int_o
);

	logic [cp0_pkg::WORD_W-1:0] index_q;
	logic [cp0_pkg::WORD_W-1:0] entrylo0_q;
	logic [cp0_pkg::WORD_W-1:0] entrylo1_q;
	logic [cp0_pkg::WORD_W-1:0] badvaddr_q;
	logic [cp0_pkg::WORD_W-1:0] count_q;
	logic [cp0_pkg::WORD_W-1:0] entryhi_q;
	logic [cp0_pkg::WORD_W-1:0] compare_q;
	logic [cp0_pkg::WORD_W-1:0] status_q;
	logic [cp0_pkg::WORD_W-1:0] cause_q;
	logic [cp0_pkg::WORD_W-1:0] epc_q;
	logic [cp0_pkg::WORD_W-1:0] ebase_q;
	logic                       timer_hit;

	// keep bits outside the mask, take the rest from the new word
	function automatic logic [cp0_pkg::WORD_W-1:0] masked(
		input logic [cp0_pkg::WORD_W-1:0] old_v,
		input logic [cp0_pkg::WORD_W-1:0] new_v,
		input logic [cp0_pkg::WORD_W-1:0] mask
	);
		return (old_v & ~mask) | (new_v & mask);
	endfunction

	assign timer_hit = (compare_q != '0) && (count_q == compare_q);

	// later assignments win, so the order below sets precedence
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			index_q     <= '0;
			entrylo0_q  <= '0;
			entrylo1_q  <= '0;
			badvaddr_q  <= '0;
			count_q     <= '0;
			entryhi_q   <= '0;
			compare_q   <= '0;
			status_q    <= cp0_pkg::STATUS_RESET;
			cause_q     <= '0;
			epc_q       <= '0;
			ebase_q     <= cp0_pkg::EBASE_RESET | {22'd0, CPU_NUM};
			timer_int_o <= 1'b0;
		end else begin
			count_q <= count_q + 32'd1;	// free running

			if (timer_hit) begin
				timer_int_o <= 1'b1;
			end

			if (we_i) begin
				case (waddr_i)
					cp0_pkg::REG_INDEX: begin
						index_q <= masked(index_q, wdata_i, cp0_pkg::MASK_INDEX);
					end
					cp0_pkg::REG_ENTRYLO0: begin
						entrylo0_q <= masked(entrylo0_q, wdata_i, cp0_pkg::MASK_ENTRYLO);
					end
					cp0_pkg::REG_ENTRYLO1: begin
						entrylo1_q <= masked(entrylo1_q, wdata_i, cp0_pkg::MASK_ENTRYLO);
					end
					cp0_pkg::REG_BADVADDR: begin
						badvaddr_q <= wdata_i;
					end
					cp0_pkg::REG_COUNT: begin
						count_q <= wdata_i;
					end
					cp0_pkg::REG_ENTRYHI: begin
						entryhi_q <= masked(entryhi_q, wdata_i, cp0_pkg::MASK_ENTRYHI);
					end
					cp0_pkg::REG_COMPARE: begin
						compare_q   <= wdata_i;
						timer_int_o <= 1'b0;	// writing compare acks the timer
					end
					cp0_pkg::REG_STATUS: begin
						status_q <= wdata_i;
					end
					cp0_pkg::REG_CAUSE: begin
						cause_q <= masked(cause_q, wdata_i, cp0_pkg::MASK_CAUSE_W);
					end
					cp0_pkg::REG_EPC: begin
						epc_q <= wdata_i;
					end
					cp0_pkg::REG_EBASE: begin
						ebase_q <= masked(ebase_q, wdata_i, cp0_pkg::MASK_EBASE);
					end
					default: begin
					end
				endcase
			end

			// ip7..2 track the pins, timer shares ip7
			cause_q[15:10] <= {int_i[5] | timer_int_o, int_i[4:0]};

			if (exc_take_i) begin
				// nested exception keeps the first epc and bd
				if (!status_q[1]) begin
					epc_q       <= exc_epc_i;
					cause_q[31] <= exc_bd_i;
				end
				status_q[1]  <= 1'b1;	// exl
				cause_q[6:2] <= exc_code_i;
			end else if (exc_eret_i) begin
				status_q[1] <= 1'b0;
			end
		end
	end

	always_comb begin
		case (raddr_i)
			cp0_pkg::REG_INDEX:    rdata_o = index_q;
			cp0_pkg::REG_ENTRYLO0: rdata_o = entrylo0_q;
			cp0_pkg::REG_ENTRYLO1: rdata_o = entrylo1_q;
			cp0_pkg::REG_BADVADDR: rdata_o = badvaddr_q;
			cp0_pkg::REG_COUNT:    rdata_o = count_q;
			cp0_pkg::REG_ENTRYHI:  rdata_o = entryhi_q;
			cp0_pkg::REG_COMPARE:  rdata_o = compare_q;
			cp0_pkg::REG_STATUS:   rdata_o = status_q;
			cp0_pkg::REG_CAUSE:    rdata_o = cause_q;
			cp0_pkg::REG_EPC:      rdata_o = epc_q;
			cp0_pkg::REG_EBASE:    rdata_o = ebase_q;
			default:               rdata_o = '0;	// unimplemented regs
		endcase
	end

	assign status_o = status_q;
	assign cause_o  = cause_q;
	assign epc_o    = epc_q;
	assign ebase_o  = ebase_q;

endmodule

`default_nettype wire

/* verilog/except_prioritizer.sv */
`timescale 1ns/100ps
`default_nettype none

module except_prioritizer (
	// committing instruction
	input  wire                        commit_valid_i,
	input  wire  [cp0_pkg::FLAG_N-1:0] exc_flags_i,
	input  wire                        eret_i,
	input  wire  [cp0_pkg::WORD_W-1:0] inst_addr_i,
	input  wire                        in_delay_slot_i,

	// current cp0 state
	input  wire  [cp0_pkg::WORD_W-1:0] status_i,
	input  wire  [cp0_pkg::WORD_W-1:0] cause_i,
	input  wire  [cp0_pkg::WORD_W-1:0] epc_i,
	input  wire  [cp0_pkg::WORD_W-1:0] ebase_i,

	// capture request to the register file
	output logic                       take_o,
	output logic [4:0]                 code_o,
	output logic                       eret_o,
	output logic [cp0_pkg::WORD_W-1:0] epc_new_o,
	output logic                       bd_o,

	// pipeline redirect
	output logic                       flush_o,
	output logic [cp0_pkg::WORD_W-1:0] new_pc_o
);

	logic                       int_pending;
	logic                       any_exc;
	logic [4:0]                 code;
	logic [cp0_pkg::WORD_W-1:0] vector;

	// ie set, exl clear, some unmasked ip bit
	assign int_pending = status_i[0] && !status_i[1] &&
		(|(cause_i[15:8] & status_i[15:8]));

	always_comb begin
		any_exc = 1'b1;
		code    = cp0_pkg::EXC_INT;
		if (int_pending) begin
			code = cp0_pkg::EXC_INT;
		end else if (exc_flags_i[cp0_pkg::FLAG_ADEL]) begin
			code = cp0_pkg::EXC_ADEL;	// fetch side first
		end else if (exc_flags_i[cp0_pkg::FLAG_TLBL]) begin
			code = cp0_pkg::EXC_TLBL;
		end else if (exc_flags_i[cp0_pkg::FLAG_RI]) begin
			code = cp0_pkg::EXC_RI;
		end else if (exc_flags_i[cp0_pkg::FLAG_CPU]) begin
			code = cp0_pkg::EXC_CPU;
		end else if (exc_flags_i[cp0_pkg::FLAG_SYS]) begin
			code = cp0_pkg::EXC_SYS;
		end else if (exc_flags_i[cp0_pkg::FLAG_ADES]) begin
			code = cp0_pkg::EXC_ADES;	// then data side
		end else if (exc_flags_i[cp0_pkg::FLAG_TLBS]) begin
			code = cp0_pkg::EXC_TLBS;
		end else if (exc_flags_i[cp0_pkg::FLAG_MOD]) begin
			code = cp0_pkg::EXC_MOD;
		end else if (exc_flags_i[cp0_pkg::FLAG_WATCH]) begin
			code = cp0_pkg::EXC_WATCH;
		end else begin
			any_exc = 1'b0;
		end
	end

	assign take_o = commit_valid_i && any_exc;
	assign code_o = code;
	assign eret_o = commit_valid_i && eret_i && !any_exc;	// any exception beats eret

	// branch owns the slot, so epc points back at it
	assign epc_new_o = in_delay_slot_i ? (inst_addr_i - 32'd4) : inst_addr_i;
	assign bd_o      = in_delay_slot_i;

	assign vector = {ebase_i[31:12], 12'h000} + cp0_pkg::VEC_OFFSET;

	assign flush_o = take_o || eret_o;

	always_comb begin
		if (take_o) begin
			new_pc_o = vector;
		end else if (eret_o) begin
			new_pc_o = epc_i;
		end else begin
			new_pc_o = '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/cp0_access_port.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_access_port (
	input  wire                        clk,
	input  wire                        arst_n_i,

	// host side, four-phase req/ack
	input  wire                        req_i,
	input  wire                        we_i,
	input  wire  [4:0]                 addr_i,
	input  wire  [cp0_pkg::WORD_W-1:0] wdata_i,
	output logic                       ack_o,
	output logic [cp0_pkg::WORD_W-1:0] rdata_o,

	// register file side
	input  wire  [cp0_pkg::WORD_W-1:0] reg_rdata_i,
	output logic                       reg_we_o,
	output logic [4:0]                 reg_addr_o,
	output logic [cp0_pkg::WORD_W-1:0] reg_wdata_o
);

	typedef enum logic {
		IDLE,
		BUSY
	} state_t;

	state_t state_q;
	logic   access;

	// a request seen in idle is the access; busy ignores a held req
	assign access = (state_q == IDLE) && req_i;

	assign reg_we_o    = access && we_i;	// single strobe per request
	assign reg_addr_o  = addr_i;
	assign reg_wdata_o = wdata_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			rdata_o <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (access) begin
						state_q <= BUSY;
						rdata_o <= reg_rdata_i;	// pre-write value on a write
					end
				end
				BUSY: begin
					// hold data until the host lets go
					if (!req_i) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	assign ack_o = (state_q == BUSY);

endmodule

`default_nettype wire

/* verilog/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

	localparam int WORD_W = 32;
	localparam int FLAG_N = 9;

	// cp0 register numbers, sel 0 unless noted
	localparam logic [4:0] REG_INDEX    = 5'd0;
	localparam logic [4:0] REG_ENTRYLO0 = 5'd2;
	localparam logic [4:0] REG_ENTRYLO1 = 5'd3;
	localparam logic [4:0] REG_BADVADDR = 5'd8;
	localparam logic [4:0] REG_COUNT    = 5'd9;
	localparam logic [4:0] REG_ENTRYHI  = 5'd10;
	localparam logic [4:0] REG_COMPARE  = 5'd11;
	localparam logic [4:0] REG_STATUS   = 5'd12;
	localparam logic [4:0] REG_CAUSE    = 5'd13;
	localparam logic [4:0] REG_EPC      = 5'd14;
	localparam logic [4:0] REG_EBASE    = 5'd15;	// sel 1

	// exccode field values, cause[6:2]
	localparam logic [4:0] EXC_INT   = 5'd0;
	localparam logic [4:0] EXC_MOD   = 5'd1;
	localparam logic [4:0] EXC_TLBL  = 5'd2;
	localparam logic [4:0] EXC_TLBS  = 5'd3;
	localparam logic [4:0] EXC_ADEL  = 5'd4;
	localparam logic [4:0] EXC_ADES  = 5'd5;
	localparam logic [4:0] EXC_SYS   = 5'd8;
	localparam logic [4:0] EXC_RI    = 5'd10;
	localparam logic [4:0] EXC_CPU   = 5'd11;
	localparam logic [4:0] EXC_WATCH = 5'd23;

	// bit positions in the pipeline exception flag vector
	localparam int FLAG_MOD   = 0;
	localparam int FLAG_TLBL  = 1;
	localparam int FLAG_TLBS  = 2;
	localparam int FLAG_ADEL  = 3;
	localparam int FLAG_ADES  = 4;
	localparam int FLAG_SYS   = 5;
	localparam int FLAG_RI    = 6;
	localparam int FLAG_CPU   = 7;
	localparam int FLAG_WATCH = 8;

	localparam logic [31:0] STATUS_RESET = 32'h1000_0000;	// cu0 only
	localparam logic [31:0] EBASE_RESET  = 32'h8000_0000;	// cpu number goes in [9:0]
	localparam logic [31:0] VEC_OFFSET   = 32'h0000_0180;	// general exception vector

	// writable bits per register
	localparam logic [31:0] MASK_INDEX   = 32'h0000_003F;
	localparam logic [31:0] MASK_ENTRYLO = 32'h03FF_FFFF;
	localparam logic [31:0] MASK_ENTRYHI = 32'hFFFF_E0FF;
	localparam logic [31:0] MASK_CAUSE_W = 32'h00C0_0300;	// ip1..0, wp, iv
	localparam logic [31:0] MASK_EBASE   = 32'hBFFF_F3FF;

endpackage

`default_nettype wire
